// File: source/cpu_isa_pkg.sv
package cpu_isa_pkg;

  localparam int NUM_REGS = 16;

  typedef logic [15:0] word_t;
  typedef logic [$clog2(NUM_REGS)-1:0] reg_num_t;

  // numeric values match the existing program images
  typedef enum logic [7:0] {
    JMP       = 8'd1,   // operand is the new logical pc
    RAM2REG   = 8'd2,   // reg = mem[operand]
    REG2RAM   = 8'd3,   // mem[operand] = reg
    NUM2REG   = 8'd4,   // reg = operand
    REG_PLUS  = 8'd5,   // reg += operand
    REG_MINUS = 8'd6,   // reg -= operand
    EXIT      = 8'd17   // stop until reset
  } opcode_t;

  // first word of an instruction, the second word is the operand
  typedef struct packed {
    logic [7:0] op;
    logic [7:0] reg_field;   // low nibble only
  } instr_hi_t;

endpackage

// File: source/mem_map_pkg.sv
package mem_map_pkg;

  localparam int ADDR_W = 10;
  localparam int PAGE_W = 6;                      // 64 words per page
  localparam int PAGE_IDX_W = ADDR_W - PAGE_W;
  localparam int NUM_PAGES = 1 << PAGE_IDX_W;
  localparam int RAM_WORDS = 1 << ADDR_W;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [PAGE_IDX_W-1:0] page_idx_t;     // logical and physical pages
  typedef logic [PAGE_W-1:0] page_off_t;

  localparam addr_t PROG_START = '0;             // logical address of first instruction

endpackage

// File: source/cpu_ifs.sv
// address translation between sequencer and MMU
interface xlate_if;
  import mem_map_pkg::*;

  logic req;      // one-cycle request
  logic done;     // one-cycle completion
  addr_t vaddr;   // held by the core until done
  addr_t paddr;   // valid while done is high

  modport core (
    output req,
    output vaddr,
    input  done,
    input  paddr
  );

  modport mapper (
    input  req,
    input  vaddr,
    output done,
    output paddr
  );
endinterface

interface ram_if;
  import mem_map_pkg::*;
  import cpu_isa_pkg::*;

  logic we;
  addr_t waddr;
  word_t wdata;
  logic re;
  addr_t raddr;
  word_t rdata;   // valid the cycle after re

  modport core (output we, output waddr, output wdata, output re, output raddr, input rdata);
  modport target (input we, input waddr, input wdata, input re, input raddr, output rdata);
endinterface

// File: source/block_ram.sv
module block_ram (
  input logic clka,
  ram_if.target ram,
  input logic load_en,
  input mem_map_pkg::addr_t load_addr,
  input cpu_isa_pkg::word_t load_data
);
  import mem_map_pkg::*;
  import cpu_isa_pkg::*;

  word_t mem [RAM_WORDS];
  logic wr_en;
  addr_t wr_addr;
  word_t wr_data;

  // loader owns the write port while it is active
  assign wr_en = load_en | ram.we;
  assign wr_addr = load_en ? load_addr : ram.waddr;
  assign wr_data = load_en ? load_data : ram.wdata;

  always_ff @(posedge clka) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
    if (ram.re) begin
      ram.rdata <= mem[ram.raddr];   // registered read
    end
  end

endmodule

// File: source/page_mapper.sv
module page_mapper (
  input logic clka,
  input logic rst,
  xlate_if.mapper xlate
);
  import mem_map_pkg::*;

  typedef enum logic [1:0] {
    M_IDLE,
    M_WALK,   // follow the chain from page 0
    M_SCAN,   // look for a free physical page
    M_FULL
  } map_state_t;

  map_state_t state;
  page_idx_t chain [NUM_PAGES];   // next physical page, 0 ends the chain
  page_idx_t owner [NUM_PAGES];   // logical page held by each physical page
  logic used [NUM_PAGES];
  page_idx_t walk_ptr;
  page_idx_t tail_ptr;            // last entry of the chain
  page_idx_t scan_ptr;
  page_idx_t free_ptr;            // lowest page that may still be free
  page_idx_t last_lpage;
  page_idx_t last_ppage;
  page_idx_t lpage;
  page_off_t offset;

  assign lpage = xlate.vaddr[ADDR_W-1:PAGE_W];
  assign offset = xlate.vaddr[PAGE_W-1:0];

  // last_ppage is updated on the same edge that raises done
  assign xlate.paddr = {last_ppage, offset};

  always_ff @(posedge clka) begin
    if (!rst) begin
      state <= M_IDLE;
      xlate.done <= 1'b0;
      for (int i = 0; i < NUM_PAGES; i++) begin
        chain[i] <= '0;
        owner[i] <= '0;
        used[i] <= 1'b0;
      end
      used[0] <= 1'b1;            // physical 0 holds logical 0
      free_ptr <= page_idx_t'(1);
      last_lpage <= '0;
      last_ppage <= '0;
      walk_ptr <= '0;
      tail_ptr <= '0;
      scan_ptr <= '0;
    end else begin
      xlate.done <= 1'b0;
      case (state)
        M_IDLE: begin
          if (xlate.req) begin
            if (lpage == last_lpage) begin
              xlate.done <= 1'b1;  // same page as last time
            end else begin
              walk_ptr <= '0;
              state <= M_WALK;
            end
          end
        end
        M_WALK: begin
          if (owner[walk_ptr] == lpage) begin
            last_lpage <= lpage;
            last_ppage <= walk_ptr;
            xlate.done <= 1'b1;
            state <= M_IDLE;
          end else if (chain[walk_ptr] == '0) begin
            tail_ptr <= walk_ptr;   // end of chain, need a new page
            scan_ptr <= free_ptr;
            state <= M_SCAN;
          end else begin
            walk_ptr <= chain[walk_ptr];
          end
        end
        M_SCAN: begin
          if (!used[scan_ptr]) begin
            used[scan_ptr] <= 1'b1;
            owner[scan_ptr] <= lpage;
            chain[scan_ptr] <= '0;
            chain[tail_ptr] <= scan_ptr;   // append to chain
            free_ptr <= scan_ptr + 1'b1;
            last_lpage <= lpage;
            last_ppage <= scan_ptr;
            xlate.done <= 1'b1;
            state <= M_IDLE;
          end else if (scan_ptr == page_idx_t'(NUM_PAGES - 1)) begin
            state <= M_FULL;
          end else begin
            scan_ptr <= scan_ptr + 1'b1;
          end
        end
        default: begin
          state <= M_FULL;   // out of pages, stuck until reset
        end
      endcase
    end
  end

endmodule

// File: source/exec_core.sv
module exec_core (
  input logic clka,
  input logic rst,
  input logic run,
  xlate_if.core xlate,
  ram_if.core ram,
  output logic reg_wr,
  output cpu_isa_pkg::reg_num_t reg_wr_num,
  output cpu_isa_pkg::word_t reg_wr_data,
  output logic halted
);
  import cpu_isa_pkg::*;
  import mem_map_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE,
    S_XREQ,     // raise translate request
    S_XWAIT,    // wait for done
    S_RDATA,    // read data arrives
    S_DECODE,
    S_STORE,
    S_HALT
  } stage_t;

  // what the current translation is for
  typedef enum logic [1:0] {
    K_FETCH0,
    K_FETCH1,
    K_LOAD,
    K_STORE
  } xkind_t;

  stage_t stage;
  xkind_t xkind;
  addr_t pc;
  addr_t st_addr;
  instr_hi_t ir_hi;
  word_t ir_lo;               // operand word
  word_t regs [NUM_REGS];
  opcode_t op;
  reg_num_t rnum;
  word_t rval;

  assign op = opcode_t'(ir_hi.op);
  assign rnum = ir_hi.reg_field[$bits(reg_num_t)-1:0];
  assign rval = regs[rnum];
  assign halted = (stage == S_HALT);

  // fetches translate the pc, data accesses the operand
  assign xlate.req = (stage == S_XREQ);
  assign xlate.vaddr = (xkind == K_FETCH0 || xkind == K_FETCH1) ? pc : ir_lo[ADDR_W-1:0];

  // read issued in the done cycle, store one cycle later
  assign ram.re = (stage == S_XWAIT) && xlate.done && (xkind != K_STORE);
  assign ram.raddr = xlate.paddr;
  assign ram.we = (stage == S_STORE);
  assign ram.waddr = st_addr;
  assign ram.wdata = rval;

  // register file write port
  always_comb begin
    reg_wr = 1'b0;
    reg_wr_num = rnum;
    reg_wr_data = ir_lo;
    if (stage == S_DECODE) begin
      case (op)
        NUM2REG: begin
          reg_wr = 1'b1;
        end
        REG_PLUS: begin
          reg_wr = 1'b1;
          reg_wr_data = rval + ir_lo;   // wraps at 16 bits
        end
        REG_MINUS: begin
          reg_wr = 1'b1;
          reg_wr_data = rval - ir_lo;
        end
        default: begin
          reg_wr = 1'b0;
        end
      endcase
    end else if (stage == S_RDATA && xkind == K_LOAD) begin
      reg_wr = 1'b1;
      reg_wr_data = ram.rdata;
    end
  end

  always_ff @(posedge clka) begin
    if (reg_wr) begin
      regs[reg_wr_num] <= reg_wr_data;
    end
  end

  always_ff @(posedge clka) begin
    if (stage == S_XWAIT && xlate.done) begin
      st_addr <= xlate.paddr;
    end
    if (stage == S_RDATA && xkind == K_FETCH0) begin
      ir_hi <= instr_hi_t'(ram.rdata);
    end
    if (stage == S_RDATA && xkind == K_FETCH1) begin
      ir_lo <= ram.rdata;
    end
  end

  always_ff @(posedge clka) begin
    if (!rst) begin
      stage <= S_IDLE;
      xkind <= K_FETCH0;
      pc <= PROG_START;
    end else begin
      case (stage)
        S_IDLE: begin
          if (run) begin
            xkind <= K_FETCH0;
            stage <= S_XREQ;
          end
        end
        S_XREQ: begin
          stage <= S_XWAIT;
        end
        S_XWAIT: begin
          if (xlate.done) begin
            stage <= (xkind == K_STORE) ? S_STORE : S_RDATA;
          end
        end
        S_RDATA: begin
          case (xkind)
            K_FETCH0: begin
              pc <= pc + 1'b1;
              xkind <= K_FETCH1;
              stage <= S_XREQ;
            end
            K_FETCH1: begin
              pc <= pc + 1'b1;
              stage <= S_DECODE;
            end
            default: begin
              xkind <= K_FETCH0;   // load written back, next instruction
              stage <= S_XREQ;
            end
          endcase
        end
        S_DECODE: begin
          xkind <= K_FETCH0;
          case (op)
            JMP: begin
              pc <= ir_lo[ADDR_W-1:0];
              stage <= S_XREQ;
            end
            RAM2REG: begin
              xkind <= K_LOAD;
              stage <= S_XREQ;
            end
            REG2RAM: begin
              xkind <= K_STORE;
              stage <= S_XREQ;
            end
            EXIT: begin
              stage <= S_HALT;
            end
            default: begin
              stage <= S_XREQ;   // register ops and unknown codes
            end
          endcase
        end
        S_STORE: begin
          xkind <= K_FETCH0;
          stage <= S_XREQ;
        end
        S_HALT: begin
          stage <= S_HALT;
        end
        default: begin
          stage <= S_IDLE;
        end
      endcase
    end
  end

endmodule

// File: source/cpu_top.sv
module cpu_top (
  input logic clka,
  input logic rst,
  input logic run,
  input logic load_en,
  input mem_map_pkg::addr_t load_addr,
  input cpu_isa_pkg::word_t load_data,
  output logic reg_wr,
  output cpu_isa_pkg::reg_num_t reg_wr_num,
  output cpu_isa_pkg::word_t reg_wr_data,
  output logic mem_wr,
  output mem_map_pkg::addr_t mem_wr_addr,
  output cpu_isa_pkg::word_t mem_wr_data,
  output logic halted
);

  xlate_if xlate ();
  ram_if ram ();

  exec_core exec_core_inst (
    .clka        (clka),
    .rst         (rst),
    .run         (run),
    .xlate       (xlate.core),
    .ram         (ram.core),
    .reg_wr      (reg_wr),
    .reg_wr_num  (reg_wr_num),
    .reg_wr_data (reg_wr_data),
    .halted      (halted)
  );

  page_mapper page_mapper_inst (
    .clka  (clka),
    .rst   (rst),
    .xlate (xlate.mapper)
  );

  block_ram block_ram_inst (
    .clka      (clka),
    .ram       (ram.target),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data)
  );

  assign mem_wr = ram.we;   // physical store strobe
  assign mem_wr_addr = ram.waddr;
  assign mem_wr_data = ram.wdata;

endmodule

// File: test/cpu_props.sv
module cpu_props (
  input logic clka,
  input logic rst,
  input logic run,
  input logic reg_wr,
  input logic mem_wr,
  input logic halted
);

  // register writes and stores come from different core stages
  one_strobe_a : assert property (@(posedge clka) disable iff (!rst)
    !(reg_wr && mem_wr))
    else $error("reg_wr and mem_wr high in the same cycle");

  halt_holds_a : assert property (@(posedge clka) disable iff (!rst)
    halted |=> halted)
    else $error("halted dropped without a reset");

  halt_quiet_a : assert property (@(posedge clka) disable iff (!rst)
    halted |=> !(reg_wr || mem_wr))
    else $error("write strobe after halt");

  // core must idle until started
  run_gate_a : assert property (@(posedge clka) disable iff (!rst)
    !run |-> !(reg_wr || mem_wr))
    else $error("write strobe while run is low");

endmodule

bind cpu_top cpu_props cpu_props_inst (
  .clka   (clka),
  .rst    (rst),
  .run    (run),
  .reg_wr (reg_wr),
  .mem_wr (mem_wr),
  .halted (halted)
);

// File: test/cpu_tb.sv
module cpu_tb;
  import cpu_isa_pkg::*;
  import mem_map_pkg::*;

  typedef enum logic [1:0] {EV_NONE, EV_REG, EV_MEM} ev_kind_t;

  typedef struct packed {
    logic [7:0] op;
    logic [3:0] rn;
    word_t operand;
    ev_kind_t kind;   // strobe this row should give
  } row_t;

  typedef struct packed {
    ev_kind_t kind;
    word_t target;    // register number or physical address
    word_t data;
  } strobe_t;

  localparam int NUM_ROWS = 20;
  localparam int TIMEOUT_CYCLES = NUM_ROWS * 40 + NUM_ROWS * 6;   // run, then load and reset

  // a program ends at its EXIT row, row n of a program sits at pc 2n
  row_t stim_rows [NUM_ROWS] = '{
    '{NUM2REG,   4'd1, 16'hfff0, EV_REG},
    '{REG_PLUS,  4'd1, 16'h0025, EV_REG},   // wraps past ffff
    '{REG_MINUS, 4'd1, 16'h0020, EV_REG},
    '{NUM2REG,   4'd2, 16'h0003, EV_REG},
    '{REG_MINUS, 4'd2, 16'h0005, EV_REG},   // wraps below zero
    '{EXIT,      4'd0, 16'h0000, EV_NONE},
    '{RAM2REG,   4'd3, 16'h0085, EV_REG},   // logical page 2, first touch
    '{REG_PLUS,  4'd3, 16'h0001, EV_REG},
    '{REG2RAM,   4'd3, 16'h0150, EV_MEM},   // logical page 5
    '{RAM2REG,   4'd4, 16'h0150, EV_REG},   // reads the store back
    '{REG2RAM,   4'd4, 16'h00a0, EV_MEM},   // page 2 again
    '{RAM2REG,   4'd5, 16'h0090, EV_REG},
    '{EXIT,      4'd0, 16'h0000, EV_NONE},
    '{NUM2REG,   4'd6, 16'h1234, EV_REG},
    '{JMP,       4'd0, 16'h0008, EV_NONE},
    '{NUM2REG,   4'd6, 16'hdead, EV_NONE},  // skipped
    '{REG2RAM,   4'd6, 16'h0100, EV_NONE},  // skipped
    '{8'h09,     4'd6, 16'h0077, EV_NONE},  // unknown code
    '{REG_PLUS,  4'd6, 16'h0001, EV_REG},
    '{EXIT,      4'd0, 16'h0000, EV_NONE}
  };

  logic clka = 1'b0;
  logic rst;
  logic run;
  logic load_en;
  addr_t load_addr;
  word_t load_data;
  logic reg_wr;
  reg_num_t reg_wr_num;
  word_t reg_wr_data;
  logic mem_wr;
  addr_t mem_wr_addr;
  word_t mem_wr_data;
  logic halted;

  int cycles = 0;
  strobe_t exp_q [$];
  word_t model_regs [NUM_REGS];
  word_t model_mem [int];          // keyed by physical address
  page_idx_t page_map [NUM_PAGES];
  logic page_known [NUM_PAGES];
  page_idx_t next_page;
  addr_t preload_addr [$];
  word_t preload_data [$];

  cpu_top cpu_top_inst (.*);

  always #4 clka = ~clka;

  always @(posedge clka) begin
    cycles <= cycles + 1;
    if (cycles > TIMEOUT_CYCLES) begin
      report_failure("timeout, the core did not finish the programs");
    end
  end

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Regression failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      report_failure($sformatf("Error: %s is %h, expected %h", name, got, exp));
    end
  endtask

  task automatic step_cycle();
    @(posedge clka);
    #1;
  endtask

  task automatic load_word(input addr_t addr, input word_t data);
    load_en = 1'b1;
    load_addr = addr;
    load_data = data;
    step_cycle();
    load_en = 1'b0;
  endtask

  function automatic addr_t phys_addr(input word_t vaddr);
    page_idx_t lp;
    lp = vaddr[ADDR_W-1:PAGE_W];
    if (!page_known[lp]) begin   // first touch takes the next physical page
      page_known[lp] = 1'b1;
      page_map[lp] = next_page;
      next_page = next_page + 1'b1;
    end
    return {page_map[lp], vaddr[PAGE_W-1:0]};
  endfunction

  task automatic predict_program(input int first, input int last);
    row_t r;
    addr_t pa;
    strobe_t ev;
    int jump_to;
    jump_to = 0;
    foreach (page_known[p]) begin
      page_known[p] = 1'b0;
    end
    page_known[0] = 1'b1;   // program page is physical 0
    page_map[0] = '0;
    next_page = page_idx_t'(1);
    model_mem.delete();
    for (int i = first; i <= last; i++) begin
      r = stim_rows[i];
      if (2 * (i - first) < jump_to) begin
        continue;   // jumped over
      end
      pa = '0;
      case (r.op)
        NUM2REG: model_regs[r.rn] = r.operand;
        REG_PLUS: model_regs[r.rn] = model_regs[r.rn] + r.operand;
        REG_MINUS: model_regs[r.rn] = model_regs[r.rn] - r.operand;
        RAM2REG: begin
          pa = phys_addr(r.operand);
          if (!model_mem.exists(int'(pa))) begin
            model_mem[int'(pa)] = word_t'($urandom);
            preload_addr.push_back(pa);
            preload_data.push_back(model_mem[int'(pa)]);
          end
          model_regs[r.rn] = model_mem[int'(pa)];
        end
        REG2RAM: begin
          pa = phys_addr(r.operand);
          model_mem[int'(pa)] = model_regs[r.rn];
        end
        JMP: jump_to = int'(r.operand);
        default: begin
        end
      endcase
      ev.kind = r.kind;
      ev.target = (r.kind == EV_MEM) ? word_t'(pa) : word_t'(r.rn);
      ev.data = model_regs[r.rn];
      if (r.kind != EV_NONE) begin
        exp_q.push_back(ev);
      end
    end
  endtask

  task automatic run_program(input int first, input int last);
    strobe_t exp;
    int quiet;
    exp_q.delete();
    preload_addr.delete();
    preload_data.delete();
    rst = 1'b0;
    repeat (2) step_cycle();
    rst = 1'b1;
    check_value("halted", word_t'(halted), '0);   // core idles after reset
    predict_program(first, last);
    for (int i = first; i <= last; i++) begin
      load_word(addr_t'(2 * (i - first)), {stim_rows[i].op, 4'h0, stim_rows[i].rn});
      load_word(addr_t'(2 * (i - first) + 1), stim_rows[i].operand);
    end
    foreach (preload_addr[k]) begin
      load_word(preload_addr[k], preload_data[k]);
    end
    run = 1'b1;
    quiet = 0;
    while (quiet < 4) begin   // a few cycles past halt for late strobes
      @(negedge clka);
      if (reg_wr) begin
        if (exp_q.size() == 0 || exp_q[0].kind != EV_REG) begin
          report_failure("reg_wr strobe where no register write was expected");
        end
        exp = exp_q.pop_front();
        check_value("reg_wr_num", word_t'(reg_wr_num), exp.target);
        check_value("reg_wr_data", reg_wr_data, exp.data);
      end
      if (mem_wr) begin
        if (exp_q.size() == 0 || exp_q[0].kind != EV_MEM) begin
          report_failure("mem_wr strobe where no memory store was expected");
        end
        exp = exp_q.pop_front();
        check_value("mem_wr_addr", word_t'(mem_wr_addr), exp.target);
        check_value("mem_wr_data", mem_wr_data, exp.data);
      end
      if (halted) begin
        quiet++;
      end
    end
    if (exp_q.size() != 0) begin
      report_failure("core halted before all expected strobes came");
    end
    step_cycle();
    run = 1'b0;
  endtask

  initial begin
    int first;
    rst = 1'b0;
    run = 1'b0;
    load_en = 1'b0;
    load_addr = '0;
    load_data = '0;
    first = 0;
    void'($urandom(13));
    foreach (model_regs[i]) begin
      model_regs[i] = '0;
    end
    step_cycle();
    for (int i = 0; i < NUM_ROWS; i++) begin
      if (stim_rows[i].op == EXIT) begin
        run_program(first, i);
        first = i + 1;
      end
    end
    $display("Regression passed");
    $finish;
  end

endmodule

// File: src.f
source/cpu_isa_pkg.sv
source/mem_map_pkg.sv
source/cpu_ifs.sv
source/block_ram.sv
source/page_mapper.sv
source/exec_core.sv
source/cpu_top.sv
test/cpu_props.sv
test/cpu_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module cpu_tb -o cpu_sim

status=0
output=$(./obj_dir/cpu_sim 2>&1) || status=$?
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Regression passed"; then
  exit 0
fi
echo "simulation did not pass, exit status $status"
exit 1
